// File: all.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/drive_pkg.sv
verilog/uart_rx.sv
verilog/angle_command.sv
verilog/phase_distributor.sv
verilog/phase_channel.sv
verilog/gate_output_stage.sv
verilog/drive_top.sv
verif/tb_drive_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f all.f --top-module tb_drive_top -o sim_drive \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_drive > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "No result in log"; exit 1; }

// File: verif/tb_drive_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module tb_drive_top;
    import drive_pkg::*;

    localparam int NUM_CH      = `NUM_CHANNELS;
    localparam int PERIOD      = 1 << `PHASE_BITS;
    localparam int HIGH_TIME   = PERIOD / 2 - `DEAD_TIME;
    localparam int NUM_ROWS    = 8;
    localparam int CYCLE_LIMIT = NUM_ROWS * (2 * 20 * `BAUD_DIV + 3 * PERIOD) + 1000;

    // One command and the angle the framing rule gives for it
    typedef struct packed {
        logic [7:0]  high_byte;
        logic [7:0]  low_byte;
        logic        bad_high;
        logic        bad_low;
        logic        shoot;
        logic [11:0] angle;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 12'h000},
        '{8'h05, 8'h55, 1'b0, 1'b0, 1'b1, 12'h555},
        '{8'hF3, 8'h21, 1'b0, 1'b0, 1'b1, 12'h321},
        // Bad high byte keeps 8'hF3 from the previous command
        '{8'hAB, 8'hCD, 1'b1, 1'b0, 1'b1, 12'h3CD},
        // Bad low byte keeps 8'hCD and the new top nibble is ignored
        '{8'h43, 8'h99, 1'b0, 1'b1, 1'b1, 12'h3CD},
        '{8'h0F, 8'hFF, 1'b0, 1'b0, 1'b0, 12'hFFF},
        '{8'h0F, 8'hFF, 1'b0, 1'b0, 1'b1, 12'hFFF},
        '{8'hFA, 8'h00, 1'b0, 1'b0, 1'b1, 12'hA00}
    };

    logic                    clk24;
    logic                    reset;
    logic                    rx;
    logic                    shoot;
    gate_pair_t [NUM_CH-1:0] gates;

    int       cycle;
    int       errors;
    int       checks;
    int       bad_tests;
    bit       mon_en;
    bit       mon_en_q;
    bit [1:0] prev_gate [NUM_CH];
    int       rise_at [NUM_CH][2];
    bit       rise_ok [NUM_CH][2];
    int       low_at [NUM_CH];
    bit       low_ok [NUM_CH];
    int       last_a_rise [NUM_CH];
    int       a_rises [NUM_CH];
    int       busy_cycles;

    drive_top DUT (
        .clk24 (clk24),
        .reset (reset),
        .rx    (rx),
        .shoot (shoot),
        .gates (gates)
    );

    initial begin
        clk24 = 1'b0;
        forever #5 clk24 = ~clk24;
    end

    always @(posedge clk24) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, actual, expected, cycle);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk24);
        #1;
    endtask

    // Start, 8 data bits LSB first, even parity, stop
    task automatic send_byte(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            rx = frame[i];
            wait_cycles(`BAUD_DIV);
        end
    endtask

    task automatic report_test(input int num, input string what, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %0d (%s): ok", num, what);
        end else begin
            bad_tests++;
            $display("Test %0d (%s): %0d errors", num, what, errors - errors_before);
        end
    endtask

    // Sampled on the falling edge away from DUT updates
    always @(negedge clk24) begin
        bit [1:0] now_gate;
        if (mon_en && !mon_en_q) begin
            busy_cycles = 0;
            for (int k = 0; k < NUM_CH; k++) begin
                a_rises[k] = 0;
                low_ok[k]  = 1'b0;
                rise_ok[k] = '{1'b0, 1'b0};
            end
        end
        mon_en_q = mon_en;
        for (int k = 0; k < NUM_CH; k++) begin
            now_gate = {gates[k].b, gates[k].a};
            check_value($sformatf("gates[%0d] a and b both high", k), int'(now_gate == 2'b11), 0);
            if (mon_en && now_gate != 2'b00) busy_cycles++;
            for (int g = 0; g < 2; g++) begin
                if (now_gate[g] && !prev_gate[k][g]) begin
                    rise_at[k][g] = cycle;
                    rise_ok[k][g] = mon_en;
                    if (mon_en && low_ok[k])
                        check_value($sformatf("gates[%0d] dead time", k),
                                    cycle - low_at[k], `DEAD_TIME);
                    if (mon_en && g == 0) begin
                        last_a_rise[k] = cycle;
                        a_rises[k]++;
                    end
                end
                if (!now_gate[g] && prev_gate[k][g] && mon_en && rise_ok[k][g])
                    check_value($sformatf("gates[%0d].%s high time", k, g ? "b" : "a"),
                                cycle - rise_at[k][g], HIGH_TIME);
            end
            if (now_gate == 2'b00 && prev_gate[k] != 2'b00) begin
                low_at[k] = cycle;
                low_ok[k] = mon_en;
            end
            prev_gate[k] = now_gate;
        end
    end

    initial begin
        int   diff;
        int   expected;
        int   errors_before;
        row_t row;
        rx     = 1'b1;
        shoot  = 1'b1;
        reset  = 1'b1;
        mon_en = 1'b0;
        repeat (5) @(posedge clk24);
        #1;
        reset = 1'b0;
        wait_cycles(2);

        // Not armed yet, so no switching even with shoot high
        errors_before = errors;
        mon_en = 1'b1;
        wait_cycles(PERIOD);
        mon_en = 1'b0;
        check_value("busy cycles before any command", busy_cycles, 0);
        report_test(0, "idle after reset", errors_before);

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ROWS[i];
            errors_before = errors;
            shoot = row.shoot;
            send_byte(row.high_byte, row.bad_high);
            send_byte(row.low_byte, row.bad_low);
            // Covers rx_done, offset load and the gate pipeline
            wait_cycles(16);
            mon_en = 1'b1;
            wait_cycles(2 * PERIOD);
            mon_en = 1'b0;
            if (row.shoot) begin
                for (int k = 0; k < NUM_CH; k++) begin
                    check_value($sformatf("gates[%0d].a rising edges", k), a_rises[k], 2);
                end
                // Channel 0 is the reference for the others
                for (int k = 1; k < NUM_CH; k++) begin
                    diff = ((last_a_rise[k] - last_a_rise[0]) % PERIOD + PERIOD) % PERIOD;
                    expected = (k * int'(row.angle)) % PERIOD;
                    check_value($sformatf("gates[%0d].a phase offset", k), diff, expected);
                end
            end else begin
                check_value("busy cycles with shoot low", busy_cycles, 0);
            end
            report_test(i + 1, $sformatf("angle 0x%03h shoot %0d", row.angle, row.shoot),
                        errors_before);
        end

        $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 NUM_ROWS + 1, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/drive_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module drive_top (
    input  wire                                        clk24,
    input  wire                                        reset,
    input  wire                                        rx,
    input  wire                                        shoot,
    output drive_pkg::gate_pair_t [`NUM_CHANNELS-1:0]  gates
);
    import uart_pkg::*;
    import drive_pkg::*;

    rx_word_t                         rx_word;
    logic                             rx_done;
    angle_t                           angle;
    logic                             angle_valid;
    phase_t                           phase_now;
    channel_cfg_t [`NUM_CHANNELS-1:0] cfg;
    gate_pair_t   [`NUM_CHANNELS-1:0] pairs;

    uart_rx u_uart_rx (
        .clk24   (clk24),
        .reset   (reset),
        .rx      (rx),
        .word    (rx_word),
        .rx_done (rx_done)
    );

    angle_command u_angle_command (
        .clk24       (clk24),
        .reset       (reset),
        .word        (rx_word),
        .rx_done     (rx_done),
        .angle       (angle),
        .angle_valid (angle_valid)
    );

    phase_distributor u_phase_distributor (
        .clk24       (clk24),
        .reset       (reset),
        .angle       (angle),
        .angle_valid (angle_valid),
        .phase_now   (phase_now),
        .cfg         (cfg)
    );

    for (genvar k = 0; k < `NUM_CHANNELS; k++) begin : g_channel
        phase_channel u_phase_channel (
            .clk24     (clk24),
            .reset     (reset),
            .phase_now (phase_now),
            .cfg       (cfg[k]),
            .gate      (pairs[k])
        );
    end

    gate_output_stage u_gate_output_stage (
        .clk24 (clk24),
        .reset (reset),
        .shoot (shoot),
        .pairs (pairs),
        .gates (gates)
    );

endmodule

`default_nettype wire

// File: verilog/gate_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module gate_output_stage (
    input  wire                                        clk24,
    input  wire                                        reset,
    input  wire                                        shoot,
    input  drive_pkg::gate_pair_t [`NUM_CHANNELS-1:0]  pairs,
    output drive_pkg::gate_pair_t [`NUM_CHANNELS-1:0]  gates
);
    import drive_pkg::*;

    gate_pair_t [`NUM_CHANNELS-1:0] pairs_q;
    logic                           shoot_q;

    always_ff @(posedge clk24) begin
        if (reset) begin
            pairs_q <= '0;
            shoot_q <= 1'b0;
        end else begin
            pairs_q <= pairs;
            shoot_q <= shoot;
        end
    end

    // All gates off while not shooting
    assign gates = shoot_q ? pairs_q : '0;

    for (genvar k = 0; k < `NUM_CHANNELS; k++) begin : g_check
        assert property (@(posedge clk24) disable iff (reset)
                         !(gates[k].a && gates[k].b));
    end

endmodule

`default_nettype wire

// File: verilog/phase_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module phase_channel (
    input  wire                     clk24,
    input  wire                     reset,
    input  drive_pkg::phase_t       phase_now,
    input  drive_pkg::channel_cfg_t cfg,
    output drive_pkg::gate_pair_t   gate
);
    import drive_pkg::*;

    localparam phase_t HALF  = phase_t'(1 << (`PHASE_BITS - 1));
    localparam phase_t GUARD = phase_t'(`DEAD_TIME);

    phase_t rel_phase;
    logic   a_next;
    logic   b_next;

    // Subtraction wraps modulo the carrier period
    assign rel_phase = phase_now - cfg.phase_offset;

    // First half drives a, second half drives b
    // Each half opens DEAD_TIME late so the other side has turned off
    assign a_next = cfg.armed && (rel_phase >= GUARD) && (rel_phase < HALF);
    assign b_next = cfg.armed && (rel_phase >= HALF + GUARD);

    always_ff @(posedge clk24) begin
        if (reset) begin
            gate <= '0;
        end else begin
            gate.a <= a_next;
            gate.b <= b_next;
        end
    end

    // Shoot-through would short the supply
    assert property (@(posedge clk24) disable iff (reset) gate.a |-> !gate.b);

endmodule

`default_nettype wire

// File: verilog/phase_distributor.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module phase_distributor (
    input  wire                                          clk24,
    input  wire                                          reset,
    input  drive_pkg::angle_t                            angle,
    input  wire                                          angle_valid,
    output drive_pkg::phase_t                            phase_now,
    output drive_pkg::channel_cfg_t [`NUM_CHANNELS-1:0]  cfg
);
    import drive_pkg::*;

    phase_t offset_sum [`NUM_CHANNELS];
    phase_t offset_q   [`NUM_CHANNELS];
    logic   armed_q;

    // Carrier counter wraps once per period
    always_ff @(posedge clk24) begin
        if (reset) begin
            phase_now <= '0;
        end else begin
            phase_now <= phase_now + 1'b1;
        end
    end

    // k times the angle as a running sum, wraps modulo the period
    always_comb begin
        phase_t acc;
        acc = '0;
        for (int k = 0; k < `NUM_CHANNELS; k++) begin
            offset_sum[k] = acc;
            acc = acc + phase_t'(angle);
        end
    end

    always_ff @(posedge clk24) begin
        if (angle_valid) begin
            offset_q <= offset_sum;
        end
    end

    always_ff @(posedge clk24) begin
        if (reset) begin
            armed_q <= 1'b0;
        end else if (angle_valid) begin
            armed_q <= 1'b1;
        end
    end

    always_comb begin
        for (int k = 0; k < `NUM_CHANNELS; k++) begin
            cfg[k].phase_offset = offset_q[k];
            cfg[k].armed        = armed_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/angle_command.sv
`timescale 1ns/1ps
`default_nettype none

module angle_command (
    input  wire                 clk24,
    input  wire                 reset,
    input  uart_pkg::rx_word_t  word,
    input  wire                 rx_done,
    output drive_pkg::angle_t   angle,
    output logic                angle_valid
);
    import drive_pkg::*;

    framer_state_t state;
    command_t      command_q;

    always_ff @(posedge clk24) begin
        if (reset) begin
            state       <= WAIT_HIGH;
            command_q   <= '0;
            angle_valid <= 1'b0;
        end else begin
            // Pulse on every low byte, good or not
            angle_valid <= rx_done && (state == WAIT_LOW);
            if (rx_done) begin
                case (state)
                    WAIT_HIGH: begin
                        if (!word.parity_error) begin
                            command_q[15:8] <= word.data;
                        end
                        state <= WAIT_LOW;
                    end
                    WAIT_LOW: begin
                        if (!word.parity_error) begin
                            command_q[7:0] <= word.data;
                        end
                        state <= WAIT_HIGH;
                    end
                    default: state <= WAIT_HIGH;
                endcase
            end
        end
    end

    // Top nibble of the command is ignored
    assign angle = command_q[11:0];

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "drive_settings.svh"

module uart_rx (
    input  wire                 clk24,
    input  wire                 reset,
    input  wire                 rx,
    output uart_pkg::rx_word_t  word,
    output logic                rx_done
);
    import uart_pkg::*;
    import drive_pkg::*;

    localparam int CNT_BITS = $clog2(`BAUD_DIV);
    localparam logic [CNT_BITS-1:0] HALF_BIT = CNT_BITS'(`BAUD_DIV / 2 - 1);
    localparam logic [CNT_BITS-1:0] FULL_BIT = CNT_BITS'(`BAUD_DIV - 1);

    logic                rx_meta;
    logic                rx_sync;
    rx_state_t           state;
    logic [CNT_BITS-1:0] baud_cnt;
    logic [2:0]          bit_idx;
    logic                sample;
    uart_byte_t          shift_q;
    logic                parity_q;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk24) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Half a bit to reach mid start bit, then a full bit each
    assign sample = (state != IDLE) &&
                    (baud_cnt == ((state == START) ? HALF_BIT : FULL_BIT));

    always_ff @(posedge clk24) begin
        if (reset) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rx_done  <= 1'b0;
            baud_cnt <= (state == IDLE || sample) ? '0 : baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (!rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (sample) begin
                        bit_idx <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                end
                PARITY: begin
                    if (sample) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (sample) begin
                        rx_done <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk24) begin
        if (sample) begin
            case (state)
                DATA:   shift_q <= {rx_sync, shift_q[7:1]};
                PARITY: parity_q <= rx_sync;
                STOP: begin
                    word.data         <= shift_q;
                    // Even parity: data and parity bit XOR to zero
                    word.parity_error <= ^{shift_q, parity_q};
                end
                default: ;
            endcase
        end
    end

    // One byte per frame, so the strobe never repeats
    assert property (@(posedge clk24) disable iff (reset) rx_done |=> !rx_done);

endmodule

`default_nettype wire

// File: verilog/drive_pkg.sv
`default_nettype none

`include "drive_settings.svh"

package drive_pkg;

    // Carrier phase or phase offset
    typedef logic [`PHASE_BITS-1:0] phase_t;

    // Steering angle, low 12 bits of a command
    typedef logic [11:0] angle_t;

    // Two bytes joined, high byte first
    typedef logic [15:0] command_t;

    typedef struct packed {
        phase_t phase_offset;
        logic   armed;
    } channel_cfg_t;

    // High side a, low side b
    typedef struct packed {
        logic a;
        logic b;
    } gate_pair_t;

    typedef enum logic {WAIT_HIGH, WAIT_LOW} framer_state_t;

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rx_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // One received data byte
    typedef logic [7:0] uart_byte_t;

    // Byte as delivered by the receiver
    typedef struct packed {
        uart_byte_t data;
        logic       parity_error;
    } rx_word_t;

endpackage

`default_nettype wire

// File: verilog/drive_settings.svh
`ifndef DRIVE_SETTINGS_SVH
`define DRIVE_SETTINGS_SVH

// Transistor pairs driven by the array
`define NUM_CHANNELS 3

// clk24 cycles per serial bit, small to keep simulation short
`define BAUD_DIV 8

// Both gates off for this many cycles after each crossing
`define DEAD_TIME 4

// Phase counter width; carrier period is 2**PHASE_BITS cycles
`define PHASE_BITS 12

`endif
